/* src/cache_pkg.sv */
`default_nettype none

package cache_pkg;

	// address split
	localparam int ADDR_W   = 32;
	localparam int TAG_W    = 24;
	localparam int INDEX_W  = 4;
	localparam int OFFSET_W = 4;

	// data path
	localparam int DATA_W = 64;
	localparam int STRB_W = DATA_W / 8;

	// organization
	localparam int WAY_NUM = 2;
	localparam int SET_NUM = 1 << INDEX_W;
	localparam int BEATS   = 2;
	localparam int LINE_W  = DATA_W * BEATS;

	// cache view of a byte address
	typedef struct packed {
		logic [TAG_W-1:0]    tag;
		logic [INDEX_W-1:0]  index;
		logic                word_sel;
		logic [OFFSET_W-2:0] byte_off;
	} addr_fields_t;

	// flat on the memory side, split inside the cache
	typedef union packed {
		logic [ADDR_W-1:0] flat;
		addr_fields_t      fields;
	} addr_u;

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		WRITE,
		MISS,
		REFILL,
		RESPOND
	} ctrl_state_e;

endpackage

`default_nettype wire

/* src/cache_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ram #(
	parameter int WIDTH = 64,
	parameter int DEPTH = 16
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     cs,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] addr,
	input  logic [WIDTH-1:0]         din,
	output logic [WIDTH-1:0]         dout
);

	logic [WIDTH-1:0] mem [DEPTH];

	always_ff @(posedge clk) begin
		if (cs && we) begin
			mem[addr] <= din;
		end
	end

	// read data shows up the cycle after cs
	always_ff @(posedge clk) begin
		if (rst) begin
			dout <= '0;
		end else if (cs && !we) begin
			dout <= mem[addr];
		end
	end

endmodule

`default_nettype wire

/* src/way_port_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface way_port_if;
	import cache_pkg::*;

	// access from the controller
	logic [INDEX_W-1:0] index;
	logic               lookup_en;
	logic               word_sel;
	logic [WAY_NUM-1:0] wr_way;
	logic [BEATS-1:0]   wr_bank;
	logic [DATA_W-1:0]  wr_data;
	logic               wr_tag;
	logic [TAG_W-1:0]   tag_in;
	logic               dirty_in;
	logic               set_dirty;

	// lookup results, valid the cycle after lookup_en
	logic               hit;
	logic               hit_way;
	logic [DATA_W-1:0]  hit_word;
	logic               victim_way;
	logic               victim_valid;
	logic               victim_dirty;
	logic [TAG_W-1:0]   victim_tag;
	logic [LINE_W-1:0]  victim_line;

	modport ctrl (
		output index, lookup_en, word_sel, wr_way, wr_bank, wr_data,
		output wr_tag, tag_in, dirty_in, set_dirty,
		input  hit, hit_way, hit_word, victim_way, victim_valid,
		input  victim_dirty, victim_tag, victim_line
	);

	modport ways (
		input  index, lookup_en, word_sel, wr_way, wr_bank, wr_data,
		input  wr_tag, tag_in, dirty_in, set_dirty,
		output hit, hit_way, hit_word, victim_way, victim_valid,
		output victim_dirty, victim_tag, victim_line
	);

endinterface

`default_nettype wire

/* src/cache_ways.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ways (
	input logic    clk,
	input logic    rst,
	way_port_if.ways port
);
	import cache_pkg::*;

	logic [DATA_W-1:0] data_dout [WAY_NUM][BEATS];
	logic [TAG_W-1:0]  tag_dout [WAY_NUM];
	logic              dirty_dout [WAY_NUM];

	// per-set valid and lru bits
	logic [WAY_NUM-1:0][SET_NUM-1:0] valid;
	logic [SET_NUM-1:0]              lru;

	// state captured with the lookup
	logic               lookup_q;
	logic [TAG_W-1:0]   tag_q;
	logic [INDEX_W-1:0] idx_q;
	logic               word_q;
	logic [WAY_NUM-1:0] vld_q;
	logic               lru_q;

	logic [WAY_NUM-1:0] way_hit;
	logic               hit_sel;
	logic               victim;

	for (genvar w = 0; w < WAY_NUM; w++) begin : g_way
		for (genvar b = 0; b < BEATS; b++) begin : g_bank
			cache_ram #(.WIDTH(DATA_W), .DEPTH(SET_NUM)) i_data (
				.clk  (clk),
				.rst  (rst),
				.cs   (port.lookup_en | (port.wr_way[w] & port.wr_bank[b])),
				.we   (port.wr_way[w] & port.wr_bank[b]),
				.addr (port.index),
				.din  (port.wr_data),
				.dout (data_dout[w][b])
			);
		end

		cache_ram #(.WIDTH(TAG_W), .DEPTH(SET_NUM)) i_tag (
			.clk  (clk),
			.rst  (rst),
			.cs   (port.lookup_en | (port.wr_way[w] & port.wr_tag)),
			.we   (port.wr_way[w] & port.wr_tag),
			.addr (port.index),
			.din  (port.tag_in),
			.dout (tag_dout[w])
		);

		// written on refill and on a write hit
		cache_ram #(.WIDTH(1), .DEPTH(SET_NUM)) i_dirty (
			.clk  (clk),
			.rst  (rst),
			.cs   (port.lookup_en | (port.wr_way[w] & (port.wr_tag | port.set_dirty))),
			.we   (port.wr_way[w] & (port.wr_tag | port.set_dirty)),
			.addr (port.index),
			.din  (port.dirty_in),
			.dout (dirty_dout[w])
		);

		assign way_hit[w] = vld_q[w] && (tag_dout[w] == tag_q);
	end

	always_ff @(posedge clk) begin
		if (port.lookup_en) begin
			tag_q  <= port.tag_in;
			idx_q  <= port.index;
			word_q <= port.word_sel;
			lru_q  <= lru[port.index];
			for (int w = 0; w < WAY_NUM; w++) begin
				vld_q[w] <= valid[w][port.index];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid    <= '0;
			lru      <= '0;
			lookup_q <= 1'b0;
		end else begin
			lookup_q <= port.lookup_en;
			for (int w = 0; w < WAY_NUM; w++) begin
				if (port.wr_tag && port.wr_way[w]) begin
					valid[w][port.index] <= 1'b1;
				end
			end
			// lru points at the way not just used
			if (lookup_q && (|way_hit)) begin
				lru[idx_q] <= ~hit_sel;
			end else if (port.wr_tag) begin
				lru[port.index] <= port.wr_way[0];
			end
		end
	end

	assign hit_sel = way_hit[1];

	// an empty way first, else the lru one
	always_comb begin
		if (!vld_q[0]) begin
			victim = 1'b0;
		end else if (!vld_q[1]) begin
			victim = 1'b1;
		end else begin
			victim = lru_q;
		end
	end

	assign port.hit          = |way_hit;
	assign port.hit_way      = hit_sel;
	assign port.hit_word     = data_dout[hit_sel][word_q];
	assign port.victim_way   = victim;
	assign port.victim_valid = vld_q[victim];
	assign port.victim_dirty = dirty_dout[victim];
	assign port.victim_tag   = tag_dout[victim];

	always_comb begin
		for (int b = 0; b < BEATS; b++) begin
			port.victim_line[b*DATA_W +: DATA_W] = data_dout[victim][b];
		end
	end

endmodule

`default_nettype wire

/* src/cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
	input  logic                          clk,
	input  logic                          rst,
	way_port_if.ctrl                      port,
	input  logic                          req_valid,
	input  logic                          req_op,
	input  cache_pkg::addr_u              req_addr,
	input  logic [cache_pkg::STRB_W-1:0] wstrb,
	input  logic [cache_pkg::DATA_W-1:0] wdata,
	output logic                          addr_ok,
	output logic                          data_ok,
	output logic [cache_pkg::DATA_W-1:0] rdata,
	output logic                          mem_rd_valid,
	output logic [cache_pkg::ADDR_W-1:0] mem_rd_addr,
	input  logic                          mem_rd_dvalid,
	input  logic                          mem_rd_last,
	input  logic [cache_pkg::DATA_W-1:0] mem_rd_data,
	output logic                          mem_wr_valid,
	output logic [cache_pkg::ADDR_W-1:0] mem_wr_addr,
	output logic [cache_pkg::LINE_W-1:0] mem_wr_line,
	input  logic                          mem_wr_ready
);
	import cache_pkg::*;

	ctrl_state_e state;
	ctrl_state_e state_nxt;

	// request buffer
	logic              req_op_q;
	addr_u             req_q;
	logic [STRB_W-1:0] strb_q;
	logic [DATA_W-1:0] wdata_q;

	// hit and miss buffers
	logic [DATA_W-1:0] merged_q;
	logic              hit_way_q;
	logic              miss_way_q;
	logic              wb_need_q;
	addr_u             wb_addr_q;
	logic [LINE_W-1:0] wb_line_q;

	logic [$clog2(BEATS)-1:0] beat_q;
	logic [DATA_W-1:0]        refill_word_q;

	logic  req_take;
	logic  beat_take;
	logic  beat_is_req;
	addr_u rd_addr;

	function automatic logic [DATA_W-1:0] merge_bytes(
		input logic [DATA_W-1:0] old_word,
		input logic [DATA_W-1:0] new_word,
		input logic [STRB_W-1:0] strb
	);
		logic [DATA_W-1:0] res;
		res = old_word;
		for (int i = 0; i < STRB_W; i++) begin
			if (strb[i]) begin
				res[i*8 +: 8] = new_word[i*8 +: 8];
			end
		end
		return res;
	endfunction

	assign req_take    = req_valid && addr_ok;
	assign beat_take   = (state == REFILL) && mem_rd_dvalid;
	assign beat_is_req = beat_q == req_q.fields.word_sel;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (req_valid) begin
					state_nxt = LOOKUP;
				end
			end
			LOOKUP: begin
				if (!port.hit) begin
					state_nxt = MISS;
				end else if (req_op_q) begin
					state_nxt = WRITE;
				end else begin
					state_nxt = IDLE;
				end
			end
			WRITE: state_nxt = IDLE;
			// clean or empty victim needs no write-back
			MISS: begin
				if (!wb_need_q || mem_wr_ready) begin
					state_nxt = REFILL;
				end
			end
			REFILL: begin
				if (mem_rd_dvalid && mem_rd_last) begin
					state_nxt = RESPOND;
				end
			end
			RESPOND: state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= IDLE;
			beat_q    <= '0;
			wb_need_q <= 1'b0;
		end else begin
			state <= state_nxt;
			if (state != REFILL) begin
				beat_q <= '0;
			end else if (mem_rd_dvalid) begin
				beat_q <= beat_q + 1'b1;
			end
			if (state == LOOKUP && !port.hit) begin
				wb_need_q <= port.victim_valid && port.victim_dirty;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req_take) begin
			req_op_q <= req_op;
			req_q    <= req_addr;
			strb_q   <= wstrb;
			wdata_q  <= wdata;
		end
		if (state == LOOKUP) begin
			hit_way_q       <= port.hit_way;
			merged_q        <= merge_bytes(port.hit_word, wdata_q, strb_q);
			miss_way_q      <= port.victim_way;
			wb_addr_q.flat  <= {port.victim_tag, req_q.fields.index, {OFFSET_W{1'b0}}};
			wb_line_q       <= port.victim_line;
		end
		// keep the requested beat for the response
		if (beat_take && beat_is_req) begin
			refill_word_q <= mem_rd_data;
		end
	end

	// lookup address comes straight from the request while idle
	assign port.index     = (state == IDLE) ? req_addr.fields.index : req_q.fields.index;
	assign port.word_sel  = (state == IDLE) ? req_addr.fields.word_sel : req_q.fields.word_sel;
	assign port.tag_in    = (state == IDLE) ? req_addr.fields.tag : req_q.fields.tag;
	assign port.lookup_en = req_take;
	assign port.wr_tag    = beat_take;
	assign port.dirty_in  = req_op_q;
	assign port.set_dirty = state == WRITE;

	always_comb begin
		port.wr_way  = '0;
		port.wr_bank = '0;
		port.wr_data = merged_q;
		if (state == WRITE) begin
			port.wr_way  = WAY_NUM'(1) << hit_way_q;
			port.wr_bank = BEATS'(1) << req_q.fields.word_sel;
		end else if (beat_take) begin
			port.wr_way  = WAY_NUM'(1) << miss_way_q;
			port.wr_bank = BEATS'(1) << beat_q;
			// write miss lays its bytes over the matching beat
			if (req_op_q && beat_is_req) begin
				port.wr_data = merge_bytes(mem_rd_data, wdata_q, strb_q);
			end else begin
				port.wr_data = mem_rd_data;
			end
		end
	end

	always_comb begin
		rd_addr                 = req_q;
		rd_addr.fields.word_sel = 1'b0;
		rd_addr.fields.byte_off = '0;
	end

	assign addr_ok = state == IDLE;
	assign data_ok = (state == LOOKUP && port.hit) || (state == RESPOND);
	assign rdata   = (state == RESPOND) ? refill_word_q : port.hit_word;

	assign mem_rd_valid = state == REFILL;
	assign mem_rd_addr  = rd_addr.flat;
	assign mem_wr_valid = (state == MISS) && wb_need_q;
	assign mem_wr_addr  = wb_addr_q.flat;
	assign mem_wr_line  = wb_line_q;

endmodule

`default_nettype wire

/* src/cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_top (
	input  logic                          clk,
	input  logic                          rst,

	// cpu side
	input  logic                          req_valid,
	input  logic                          req_op,
	input  logic [cache_pkg::ADDR_W-1:0] req_addr,
	input  logic [cache_pkg::STRB_W-1:0] wstrb,
	input  logic [cache_pkg::DATA_W-1:0] wdata,
	output logic                          addr_ok,
	output logic                          data_ok,
	output logic [cache_pkg::DATA_W-1:0] rdata,

	// line refill
	output logic                          mem_rd_valid,
	output logic [cache_pkg::ADDR_W-1:0] mem_rd_addr,
	input  logic                          mem_rd_dvalid,
	input  logic                          mem_rd_last,
	input  logic [cache_pkg::DATA_W-1:0] mem_rd_data,

	// victim write-back
	output logic                          mem_wr_valid,
	output logic [cache_pkg::ADDR_W-1:0] mem_wr_addr,
	output logic [cache_pkg::LINE_W-1:0] mem_wr_line,
	input  logic                          mem_wr_ready
);

	way_port_if i_port ();

	cache_ways i_ways (
		.clk  (clk),
		.rst  (rst),
		.port (i_port.ways)
	);

	cache_ctrl i_ctrl (
		.clk           (clk),
		.rst           (rst),
		.port          (i_port.ctrl),
		.req_valid     (req_valid),
		.req_op        (req_op),
		.req_addr      (req_addr),
		.wstrb         (wstrb),
		.wdata         (wdata),
		.addr_ok       (addr_ok),
		.data_ok       (data_ok),
		.rdata         (rdata),
		.mem_rd_valid  (mem_rd_valid),
		.mem_rd_addr   (mem_rd_addr),
		.mem_rd_dvalid (mem_rd_dvalid),
		.mem_rd_last   (mem_rd_last),
		.mem_rd_data   (mem_rd_data),
		.mem_wr_valid  (mem_wr_valid),
		.mem_wr_addr   (mem_wr_addr),
		.mem_wr_line   (mem_wr_line),
		.mem_wr_ready  (mem_wr_ready)
	);

endmodule

`default_nettype wire

/* testbench/tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
	input  logic         clk,
	input  logic         rst,
	input  logic         req_valid,
	input  logic         req_op,
	input  logic [31:0]  req_addr,
	input  logic [7:0]   wstrb,
	input  logic [63:0]  wdata,
	input  logic         addr_ok,
	input  logic         data_ok,
	input  logic [63:0]  rdata,
	input  logic         mem_rd_valid,
	input  logic [31:0]  mem_rd_addr,
	input  logic         mem_wr_valid,
	input  logic [31:0]  mem_wr_addr,
	input  logic [127:0] mem_wr_line,
	input  logic         mem_wr_ready,
	input  logic [127:0] test_name,
	input  logic         exp_hit,
	output int           tests_run,
	output int           tests_failed,
	output int           stray_errs
);

	// cpu view of memory by word address
	logic [63:0] shadow [logic [28:0]];

	logic         busy;
	logic         seen_req;
	logic         test_bad;
	logic         cur_op;
	logic         cur_hit;
	logic [31:0]  cur_addr;
	logic [127:0] cur_name;
	logic [63:0]  exp_word;
	int           cycle;
	int           acc_cycle;

	// untouched words hold their own address in both halves
	function automatic logic [63:0] shadow_word(input logic [31:0] a);
		logic [28:0] key;
		key = a[31:3];
		if (shadow.exists(key)) begin
			return shadow[key];
		end
		return {key, 3'b000, key, 3'b000};
	endfunction

	initial begin
		busy         = 1'b0;
		seen_req     = 1'b0;
		test_bad     = 1'b0;
		cycle        = 0;
		tests_run    = 0;
		tests_failed = 0;
		stray_errs   = 0;
	end

	always @(posedge clk) begin : watch
		logic [63:0] w;
		logic [63:0] lo;
		logic [63:0] hi;
		cycle = cycle + 1;
		if (!rst) begin
			if (!seen_req && !addr_ok) begin
				$display("addr_ok dropped before the first request");
				stray_errs = stray_errs + 1;
			end
			if (busy && addr_ok) begin
				$display("%0s: addr_ok high while a request is open", cur_name);
				test_bad = 1'b1;
			end
			// refill asks for the line of the open request
			if (mem_rd_valid) begin
				if (!busy) begin
					$display("mem_rd_valid high with no request open");
					stray_errs = stray_errs + 1;
				end else if (mem_rd_addr !== {cur_addr[31:4], 4'h0}) begin
					$display("ERR %0s refill address expected %h actual %h",
						cur_name, {cur_addr[31:4], 4'h0}, mem_rd_addr);
					test_bad = 1'b1;
				end
			end
			if (mem_wr_valid && !busy) begin
				$display("mem_wr_valid high with no request open");
				stray_errs = stray_errs + 1;
			end
			// dirty victim must match what the cpu wrote
			if (mem_wr_valid && mem_wr_ready) begin
				lo = shadow_word(mem_wr_addr);
				hi = shadow_word(mem_wr_addr + 32'd8);
				if (mem_wr_line != {hi, lo}) begin
					$display("ERR %0s write-back expected %h actual %h",
						cur_name, {hi, lo}, mem_wr_line);
					test_bad = 1'b1;
				end
			end
			if (data_ok) begin
				if (!busy) begin
					$display("data_ok pulsed with no request open");
					stray_errs = stray_errs + 1;
				end else begin
					if (cur_hit && (cycle - acc_cycle != 1)) begin
						$display("%0s: hit answered after %0d cycles instead of one",
							cur_name, cycle - acc_cycle);
						test_bad = 1'b1;
					end
					if (!cur_op && rdata !== exp_word) begin
						$display("ERR %0s expected %h actual %h", cur_name, exp_word, rdata);
						test_bad = 1'b1;
					end
					tests_run = tests_run + 1;
					if (test_bad) begin
						tests_failed = tests_failed + 1;
						$display("fail %0s", cur_name);
					end else begin
						$display("ok   %0s", cur_name);
					end
					busy = 1'b0;
				end
			end
			if (req_valid && addr_ok) begin
				seen_req  = 1'b1;
				busy      = 1'b1;
				test_bad  = 1'b0;
				acc_cycle = cycle;
				cur_op    = req_op;
				cur_hit   = exp_hit;
				cur_addr  = req_addr;
				cur_name  = test_name;
				w         = shadow_word(req_addr);
				if (req_op) begin
					for (int i = 0; i < 8; i++) begin
						if (wstrb[i]) begin
							w[i*8 +: 8] = wdata[i*8 +: 8];
						end
					end
					shadow[req_addr[31:3]] = w;
				end else begin
					exp_word = w;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* testbench/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top;

	localparam int NUM_ROWS = 13;
	localparam int TIMEOUT  = 200;

	typedef struct {
		logic [127:0] name;
		logic         op;
		logic [31:0]  addr;
		logic [7:0]   strb;
		logic         rnd;
		logic         hit;
	} row_t;

	logic         clk;
	logic         rst;
	logic         req_valid;
	logic         req_op;
	logic [31:0]  req_addr;
	logic [7:0]   wstrb;
	logic [63:0]  wdata;
	logic         addr_ok;
	logic         data_ok;
	logic [63:0]  rdata;
	logic         mem_rd_valid;
	logic [31:0]  mem_rd_addr;
	logic         mem_rd_dvalid;
	logic         mem_rd_last;
	logic [63:0]  mem_rd_data;
	logic         mem_wr_valid;
	logic [31:0]  mem_wr_addr;
	logic [127:0] mem_wr_line;
	logic         mem_wr_ready;
	logic [127:0] test_name;
	logic         exp_hit;
	int           tests_run;
	int           tests_failed;
	int           stray_errs;

	row_t        rows [NUM_ROWS];
	logic [31:0] rng;
	logic [63:0] mem [logic [28:0]];
	logic        timed_out;

	cache_top i_dut (.*);

	tb_checker i_chk (.*);

	always #50 clk = ~clk;

	function automatic logic [31:0] xorshift();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic logic [63:0] mem_word(input logic [31:0] a);
		if (mem.exists(a[31:3])) begin
			return mem[a[31:3]];
		end
		return {a[31:3], 3'b000, a[31:3], 3'b000};
	endfunction

	// two refill beats with random gaps
	initial begin
		forever begin
			@(posedge clk);
			#1;
			if (mem_rd_valid) begin
				for (int b = 0; b < 2; b++) begin
					repeat (xorshift() % 4) begin
						@(posedge clk);
						#1;
					end
					mem_rd_dvalid = 1'b1;
					mem_rd_last   = (b == 1);
					mem_rd_data   = mem_word(mem_rd_addr + 32'(b * 8));
					@(posedge clk);
					#1;
					mem_rd_dvalid = 1'b0;
					mem_rd_last   = 1'b0;
				end
			end
		end
	end

	// write-back accepted after a random delay
	initial begin
		forever begin
			@(posedge clk);
			#1;
			if (mem_wr_valid) begin
				repeat (xorshift() % 4) begin
					@(posedge clk);
					#1;
				end
				mem_wr_ready = 1'b1;
				@(posedge clk);
				mem[mem_wr_addr[31:3]]        = mem_wr_line[63:0];
				mem[mem_wr_addr[31:3] + 29'd1] = mem_wr_line[127:64];
				#1;
				mem_wr_ready = 1'b0;
			end
		end
	end

	initial begin
		int cnt;
		rows[0]  = '{"cold_rd_miss",  1'b0, 32'h0000_1030, 8'h00, 1'b0, 1'b0};
		rows[1]  = '{"rd_hit",        1'b0, 32'h0000_1038, 8'h00, 1'b0, 1'b1};
		rows[2]  = '{"wr_hit_part",   1'b1, 32'h0000_1030, 8'h0f, 1'b1, 1'b1};
		rows[3]  = '{"rd_after_wr",   1'b0, 32'h0000_1030, 8'h00, 1'b0, 1'b1};
		rows[4]  = '{"wr_miss",       1'b1, 32'h0000_2058, 8'hf0, 1'b1, 1'b0};
		rows[5]  = '{"rd_merged",     1'b0, 32'h0000_2058, 8'h00, 1'b0, 1'b1};
		rows[6]  = '{"rd_other_word", 1'b0, 32'h0000_2050, 8'h00, 1'b0, 1'b1};
		// three tags on set 7
		rows[7]  = '{"evict_wr_a",    1'b1, 32'h0001_0070, 8'hff, 1'b1, 1'b0};
		rows[8]  = '{"evict_wr_b",    1'b1, 32'h0002_0070, 8'h3c, 1'b1, 1'b0};
		rows[9]  = '{"evict_rd_c",    1'b0, 32'h0003_0078, 8'h00, 1'b0, 1'b0};
		rows[10] = '{"reread_a",      1'b0, 32'h0001_0070, 8'h00, 1'b0, 1'b0};
		rows[11] = '{"reread_b",      1'b0, 32'h0002_0070, 8'h00, 1'b0, 1'b0};
		rows[12] = '{"rd_hit_a",      1'b0, 32'h0001_0070, 8'h00, 1'b0, 1'b1};

		rng           = 32'd545;
		timed_out     = 1'b0;
		clk           = 1'b0;
		rst           = 1'b1;
		req_valid     = 1'b0;
		req_op        = 1'b0;
		req_addr      = '0;
		wstrb         = '0;
		wdata         = '0;
		mem_rd_dvalid = 1'b0;
		mem_rd_last   = 1'b0;
		mem_rd_data   = '0;
		mem_wr_ready  = 1'b0;
		test_name     = '0;
		exp_hit       = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;

		for (int r = 0; r < NUM_ROWS; r++) begin
			@(posedge clk);
			#1;
			req_valid = 1'b1;
			req_op    = rows[r].op;
			req_addr  = rows[r].addr;
			wstrb     = rows[r].strb;
			wdata     = rows[r].rnd ? {xorshift(), xorshift()} : 64'd0;
			test_name = rows[r].name;
			exp_hit   = rows[r].hit;
			cnt       = 0;
			while (!addr_ok && cnt < TIMEOUT) begin
				@(posedge clk);
				#1;
				cnt++;
			end
			if (!addr_ok) begin
				$display("%0s: cache never raised addr_ok", rows[r].name);
				timed_out = 1'b1;
				break;
			end
			@(posedge clk);
			#1;
			req_valid = 1'b0;
			cnt       = 0;
			while (!data_ok && cnt < TIMEOUT) begin
				@(posedge clk);
				#1;
				cnt++;
			end
			if (!data_ok) begin
				$display("%0s: no data_ok, controller stuck in %s",
					rows[r].name, i_dut.i_ctrl.state.name());
				timed_out = 1'b1;
				break;
			end
		end
		@(posedge clk);
		#1;
		$display("tests: %0d run, %0d passed, %0d failed, %0d other errors",
			tests_run, tests_run - tests_failed, tests_failed, stray_errs);
		if (!timed_out && tests_failed == 0 && stray_errs == 0 && tests_run == NUM_ROWS) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
src/cache_pkg.sv
src/cache_ram.sv
src/way_port_if.sv
src/cache_ways.sv
src/cache_ctrl.sv
src/cache_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_top
OBJ_DIR   ?= obj_dir
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf $(OBJ_DIR)
